//--- verification/gf2_mul_patterns.hex
// Carry-less products over GF(2), three lines per vector
// Line 1 operand a (284 bits), line 2 operand b (284 bits), line 3 expected product (568 bits)
0
3a5c96e0123abcdf00dbeef13579bdf2468ace0deadc0de98765432fedcba1055aa33cc
0
fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff
0
0
1
3a5c96e0123abcdf00dbeef13579bdf2468ace0deadc0de98765432fedcba1055aa33cc
3a5c96e0123abcdf00dbeef13579bdf2468ace0deadc0de98765432fedcba1055aa33cc
3a5c96e0123abcdf00dbeef13579bdf2468ace0deadc0de98765432fedcba1055aa33cc
1
3a5c96e0123abcdf00dbeef13579bdf2468ace0deadc0de98765432fedcba1055aa33cc
10000000000000000
3a5c96e0123abcdf00dbeef13579bdf2468ace0deadc0de98765432fedcba1055aa33cc
3a5c96e0123abcdf00dbeef13579bdf2468ace0deadc0de98765432fedcba1055aa33cc0000000000000000
3a5c96e0123abcdf00dbeef13579bdf2468ace0deadc0de98765432fedcba1055aa33cc
10000000000000000
3a5c96e0123abcdf00dbeef13579bdf2468ace0deadc0de98765432fedcba1055aa33cc0000000000000000
80000000000000000000000000000000000000000000000000000000000000000000000
80000000000000000000000000000000000000000000000000000000000000000000000
4000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000000
fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff
fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff
5555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555555
3a5c96e0123abcdf00dbeef13579bdf2468ace0deadc0de98765432fedcba1055aa33cc
3a5c96e0123abcdf00dbeef13579bdf2468ace0deadc0de98765432fedcba1055aa33cc
0544115041145400010405444550515500005145545455010511154145515504101440445054005154445150005154414015141110050455545150454401001111444405055050
10000000000000000000000000000000000000000000000000000000000000000000001
3a5c96e0123abcdf00dbeef13579bdf2468ace0deadc0de98765432fedcba1055aa33cc
3a5c96e0123abcdf00dbeef13579bdf2468ace0deadc0de98765432fedcba1055aa33cfa5c96e0123abcdf00dbeef13579bdf2468ace0deadc0de98765432fedcba1055aa33cc

//--- gf2_mul.f
verilog/gf2_mul_pkg.sv
verilog/karatsuba_limb_mul.sv
verilog/mul_sequencer.sv
verilog/product_accumulator.sv
verilog/result_stage.sv
verilog/gf2_mul.sv
verification/gf2_mul_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the GF(2) multiplier testbench with Verilator, run it and scan the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f gf2_mul.f \
    --top-module gf2_mul_tb -o gf2_mul_sim || { echo "build failed"; exit 1; }
sim_out="$(./obj_dir/gf2_mul_sim)"
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -q "^RESULT: PASS$" && echo "simulation passed" || {
    echo "simulation failed"
    exit 1
}

//--- verification/gf2_mul_tb.sv
`timescale 1ns/1ns

module gf2_mul_tb
    import gf2_mul_pkg::*;
();

    localparam int          RESULT_CREDITS = 2;
    localparam int          NUM_VECTORS    = 10;
    localparam int          RESET_CYCLES   = 10;
    localparam int          HOLD_CYCLES    = 120;
    localparam int unsigned SEED           = 32'h3626_b75d;
    // Each vector runs in three tests and the four edge vectors once more
    localparam int          TOTAL_SENDS    = 3 * NUM_VECTORS + 4;
    localparam int          TIMEOUT_CYCLES = 60 * TOTAL_SENDS + 200;

    logic                 clk;
    logic                 reset;
    logic                 req_valid;
    mul_req_t             req;
    logic                 req_credit;
    logic                 result_valid;
    logic [PRODUCT_W-1:0] result;
    logic                 result_credit;

    // Three lines per vector hold operand a, operand b and the expected product
    logic [PRODUCT_W-1:0] patterns [0:3*NUM_VECTORS-1];
    logic [PRODUCT_W-1:0] expected_q [$];
    int                   pending_q [$];

    string test_name;
    int    error_count;
    int    errors_at_start;
    int    tests_passed;
    int    tests_failed;
    int    cycle_count;
    int    credits_held;
    int    requests_sent;
    int    results_seen;
    int    credits_owed;
    int    return_wait;
    int    gap_left;
    logic  hold_credits;

    gf2_mul #(
        .RESULT_CREDITS (RESULT_CREDITS)
    ) UUT (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .req           (req),
        .req_credit    (req_credit),
        .result_valid  (result_valid),
        .result        (result),
        .result_credit (result_credit)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: no progress after %0d cycles in test %s", cycle_count, test_name);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // ************************************************************************
    // Consumer side
    // ************************************************************************

    task automatic check_result();
        logic [PRODUCT_W-1:0] expected;
        results_seen++;
        credits_owed++;
        assert (expected_q.size() > 0) else begin
            $display("%s: a result arrived with no request outstanding", test_name);
            error_count++;
        end
        if (expected_q.size() > 0) begin
            expected = expected_q.pop_front();
            assert (result === expected) else begin
                $display("error %s: expected %h, actual %h", test_name, expected, result);
                error_count++;
            end
        end
    endtask

    // One pulse hands back one result slot
    task automatic return_credit();
        result_credit <= 1'b0;
        if (!hold_credits && credits_owed > 0) begin
            if (return_wait == 0) begin
                result_credit <= 1'b1;
                credits_owed--;
                return_wait = $urandom_range(3, 0);
            end else begin
                return_wait--;
            end
        end
    endtask

    task automatic step_clock();
        @(posedge clk);
        if (req_credit === 1'b1) begin
            credits_held++;
        end
        if (result_valid === 1'b1) begin
            check_result();
        end
        return_credit();
    endtask

    task automatic settle(input int cycles);
        repeat (cycles) begin
            step_clock();
        end
    endtask

    // ************************************************************************
    // Source side
    // ************************************************************************

    task automatic issue_cycle(input int max_gap, input logic one_at_a_time);
        int v;
        req_valid <= 1'b0;
        if (gap_left > 0) begin
            gap_left--;
        end else if (credits_held > 0 && pending_q.size() > 0
                     && (!one_at_a_time || results_seen == requests_sent)) begin
            v = pending_q.pop_front();
            req_valid  <= 1'b1;
            req.a.flat <= patterns[3*v][OPERAND_W-1:0];
            req.b.flat <= patterns[3*v+1][OPERAND_W-1:0];
            expected_q.push_back(patterns[3*v+2]);
            credits_held--;
            requests_sent++;
            gap_left = $urandom_range(max_gap, 0);
        end
    endtask

    task automatic run_stream(input int max_gap, input logic one_at_a_time);
        while (pending_q.size() > 0 || results_seen < requests_sent) begin
            step_clock();
            issue_cycle(max_gap, one_at_a_time);
        end
        req_valid <= 1'b0;
    endtask

    task automatic queue_all_vectors();
        for (int v = 0; v < NUM_VECTORS; v++) begin
            pending_q.push_back(v);
        end
    endtask

    task automatic wait_credits_home();
        while (credits_owed > 0) begin
            step_clock();
        end
        settle(2);
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = error_count;
        gap_left        = 0;
    endtask

    task automatic finish_test();
        if (error_count == errors_at_start) begin
            tests_passed++;
            $display("test %s: passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name,
                     error_count - errors_at_start);
        end
    endtask

    // ************************************************************************
    // Test sequence
    // ************************************************************************

    initial begin
        int hold_start;
        int sent_start;
        void'($urandom(SEED));
        clk           = 1'b0;
        reset         = 1'b1;
        req_valid     = 1'b0;
        req           = '0;
        result_credit = 1'b0;
        hold_credits  = 1'b0;
        error_count   = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        cycle_count   = 0;
        credits_held  = 0;
        requests_sent = 0;
        results_seen  = 0;
        credits_owed  = 0;
        return_wait   = 0;
        gap_left      = 0;
        test_name     = "setup";
        $readmemh("verification/gf2_mul_patterns.hex", patterns);

        start_test("reset");
        for (int i = 0; i < RESET_CYCLES; i++) begin
            step_clock();
            // Outputs are unknown until the first reset edge
            if (i > 0) begin
                assert (result_valid === 1'b0 && req_credit === 1'b0) else begin
                    $display("reset: an output was high while reset was held");
                    error_count++;
                end
            end
        end
        reset <= 1'b0;
        step_clock();
        assert (result_valid === 1'b0 && req_credit === 1'b0) else begin
            $display("reset: an output was high on the cycle reset fell");
            error_count++;
        end
        settle(20);
        assert (credits_held == 1) else begin
            $display("reset: %0d request credits granted after reset instead of one",
                     credits_held);
            error_count++;
        end
        finish_test();

        start_test("pattern_products");
        queue_all_vectors();
        run_stream(5, 1'b1);
        finish_test();

        // Zero, x^283 squared and all-ones operands
        start_test("edge_operands");
        pending_q.push_back(0);
        pending_q.push_back(1);
        pending_q.push_back(6);
        pending_q.push_back(7);
        run_stream(5, 1'b1);
        finish_test();

        start_test("back_to_back");
        queue_all_vectors();
        run_stream(0, 1'b0);
        settle(30);
        assert (results_seen == requests_sent) else begin
            $display("back_to_back: %0d results for %0d requests", results_seen, requests_sent);
            error_count++;
        end
        wait_credits_home();
        finish_test();

        start_test("result_backpressure");
        hold_credits = 1'b1;
        hold_start   = results_seen;
        sent_start   = requests_sent;
        queue_all_vectors();
        for (int c = 0; c < HOLD_CYCLES; c++) begin
            step_clock();
            issue_cycle(0, 1'b0);
        end
        assert (results_seen - hold_start == RESULT_CREDITS) else begin
            $display("result_backpressure: %0d results appeared while credits were held back",
                     results_seen - hold_start);
            error_count++;
        end
        hold_credits = 1'b0;
        run_stream(3, 1'b0);
        settle(30);
        assert (requests_sent - sent_start == NUM_VECTORS && results_seen == requests_sent)
        else begin
            $display("result_backpressure: %0d results for %0d requests", results_seen,
                     requests_sent);
            error_count++;
        end
        finish_test();

        $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- verilog/gf2_mul.sv
`timescale 1ns/1ns

module gf2_mul
    import gf2_mul_pkg::*;
#(
    parameter int RESULT_CREDITS = 2
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 req_valid,
    input  mul_req_t             req,
    output logic                 req_credit,
    output logic                 result_valid,
    output logic [PRODUCT_W-1:0] result,
    input  logic                 result_credit
);

    logic                 issue_valid;
    logic [LIMB_W-1:0]    limb_a;
    logic [LIMB_W-1:0]    limb_b;
    partial_t             issue_tag;
    logic                 pp_valid;
    partial_t             pp;
    logic                 sum_valid;
    logic [PRODUCT_W-1:0] sum;
    logic                 sum_ready;

    // ************************************************************************
    // Limb pair schedule, one pair per cycle
    // ************************************************************************

    mul_sequencer u_sequencer (
        .clk         (clk),
        .reset       (reset),
        .req_valid   (req_valid),
        .req         (req),
        .req_credit  (req_credit),
        .sum_ready   (sum_ready),
        .issue_valid (issue_valid),
        .limb_a      (limb_a),
        .limb_b      (limb_b),
        .issue_tag   (issue_tag)
    );

    karatsuba_limb_mul u_limb_mul (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .limb_a      (limb_a),
        .limb_b      (limb_b),
        .issue_tag   (issue_tag),
        .pp_valid    (pp_valid),
        .pp          (pp)
    );

    // ************************************************************************
    // Wide sum and result release
    // ************************************************************************

    product_accumulator u_accumulator (
        .clk       (clk),
        .reset     (reset),
        .pp_valid  (pp_valid),
        .pp        (pp),
        .sum_valid (sum_valid),
        .sum       (sum)
    );

    result_stage #(
        .RESULT_CREDITS (RESULT_CREDITS)
    ) u_result (
        .clk           (clk),
        .reset         (reset),
        .sum_valid     (sum_valid),
        .sum           (sum),
        .sum_ready     (sum_ready),
        .result_valid  (result_valid),
        .result        (result),
        .result_credit (result_credit)
    );

endmodule

//--- verilog/result_stage.sv
`timescale 1ns/1ns

module result_stage
    import gf2_mul_pkg::*;
#(
    parameter int RESULT_CREDITS = 2
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 sum_valid,
    input  logic [PRODUCT_W-1:0] sum,
    output logic                 sum_ready,
    output logic                 result_valid,
    output logic [PRODUCT_W-1:0] result,
    input  logic                 result_credit
);

    localparam int CNT_W = $clog2(RESULT_CREDITS + 1);

    logic [CNT_W-1:0]     credits;
    logic                 hold_full;
    logic [PRODUCT_W-1:0] hold_data;
    logic                 can_send;
    logic                 send_hold;
    logic                 send_direct;
    logic                 send;

    assign can_send    = (credits != '0);
    assign send_hold   = hold_full && can_send;
    // Empty holding register lets a new sum go straight out
    assign send_direct = !hold_full && sum_valid && can_send;
    assign send        = send_hold || send_direct;
    assign sum_ready   = !hold_full || can_send;

    always_ff @(posedge clk) begin
        if (reset) begin
            credits      <= CNT_W'(RESULT_CREDITS);
            hold_full    <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= send;
            credits      <= credits - CNT_W'(send) + CNT_W'(result_credit);
            if (sum_valid && !send_direct) begin
                hold_full <= 1'b1;
            end else if (send_hold) begin
                hold_full <= 1'b0;
            end
        end
    end

    // Older product leaves first
    always_ff @(posedge clk) begin
        if (sum_valid && !send_direct) begin
            hold_data <= sum;
        end
        if (send) begin
            result <= hold_full ? hold_data : sum;
        end
    end

    a_credit_bound : assert property (
        @(posedge clk) disable iff (reset)
        credits <= CNT_W'(RESULT_CREDITS)
    ) else $error("consumer returned more credits than it was given");

    // Sequencer holds its last pair until there is room here
    a_no_overrun : assert property (
        @(posedge clk) disable iff (reset)
        sum_valid |-> sum_ready
    ) else $error("finished product arrived while holding register is full");

endmodule

//--- verilog/product_accumulator.sv
`timescale 1ns/1ns

module product_accumulator
    import gf2_mul_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 pp_valid,
    input  partial_t             pp,
    output logic                 sum_valid,
    output logic [PRODUCT_W-1:0] sum
);

    logic [PRODUCT_W-1:0] shifted;

    // Limb pair (i, j) lands at bit (i + j) * LIMB_W
    assign shifted = PRODUCT_W'(pp.prod) << (pp.offset * LIMB_W);

    always_ff @(posedge clk) begin
        if (reset) begin
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= pp_valid && pp.last;
        end
    end

    // Addition over GF(2) is XOR
    always_ff @(posedge clk) begin
        if (pp_valid) begin
            if (pp.first) begin
                sum <= shifted;
            end else begin
                sum <= sum ^ shifted;
            end
        end
    end

    // A partial product right after a closed sum must open a new one
    a_first_after_last : assert property (
        @(posedge clk) disable iff (reset)
        (pp_valid && pp.last) |=> !(pp_valid && !pp.first)
    ) else $error("partial product joined a closed sum");

endmodule

//--- verilog/mul_sequencer.sv
`timescale 1ns/1ns

module mul_sequencer
    import gf2_mul_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              req_valid,
    input  mul_req_t          req,
    output logic              req_credit,
    input  logic              sum_ready,
    output logic              issue_valid,
    output logic [LIMB_W-1:0] limb_a,
    output logic [LIMB_W-1:0] limb_b,
    output partial_t          issue_tag
);

    localparam int IDX_W = STEP_W / 2;
    localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(NUM_LIMBS * NUM_LIMBS - 1);

    mul_req_t          req_q;
    logic              started;
    logic              busy;
    logic [STEP_W-1:0] step;
    logic [IDX_W-1:0]  idx_a;
    logic [IDX_W-1:0]  idx_b;
    logic              accept;
    logic              issue_go;

    assign idx_a  = step[STEP_W-1:IDX_W];
    assign idx_b  = step[IDX_W-1:0];
    assign accept = !busy && req_valid;

    // Final pair waits for the result stage, so a finished sum always has a place
    assign issue_go = busy && (step != LAST_STEP || sum_ready);

    // ************************************************************************
    // Slot control and request credits
    // ************************************************************************

    always_ff @(posedge clk) begin
        if (reset) begin
            started     <= 1'b0;
            busy        <= 1'b0;
            step        <= '0;
            issue_valid <= 1'b0;
            req_credit  <= 1'b0;
        end else begin
            started     <= 1'b1;
            issue_valid <= issue_go;
            // One credit for the single slot once out of reset
            req_credit  <= !started;
            if (accept) begin
                busy <= 1'b1;
                step <= '0;
            end else if (issue_go) begin
                step <= step + 1'b1;
                if (step == LAST_STEP) begin
                    busy       <= 1'b0;
                    req_credit <= 1'b1;
                end
            end
        end
    end

    // ************************************************************************
    // Operand capture and limb selection
    // ************************************************************************

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
        if (issue_go) begin
            limb_a           <= req_q.a.limb[idx_a];
            limb_b           <= req_q.b.limb[idx_b];
            issue_tag.prod   <= '0;
            issue_tag.offset <= OFFSET_W'(idx_a) + OFFSET_W'(idx_b);
            issue_tag.first  <= (step == '0);
            issue_tag.last   <= (step == LAST_STEP);
        end
    end

    // Source spends a credit only while the slot is free
    a_no_req_while_busy : assert property (
        @(posedge clk) disable iff (reset)
        req_valid |-> !busy
    ) else $error("request arrived while the multiplier slot is busy");

endmodule

//--- verilog/karatsuba_limb_mul.sv
`timescale 1ns/1ns

module karatsuba_limb_mul
    import gf2_mul_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              issue_valid,
    input  logic [LIMB_W-1:0] limb_a,
    input  logic [LIMB_W-1:0] limb_b,
    input  partial_t          issue_tag,
    output logic              pp_valid,
    output partial_t          pp
);

    // Low half is the wider one, so one half multiplier serves all three products
    localparam int LO_W        = (LIMB_W + 1) / 2;
    localparam int HALF_PROD_W = 2 * LO_W - 1;

    logic [LO_W-1:0]        a_lo;
    logic [LO_W-1:0]        a_hi;
    logic [LO_W-1:0]        a_mid;
    logic [LO_W-1:0]        b_lo;
    logic [LO_W-1:0]        b_hi;
    logic [LO_W-1:0]        b_mid;
    logic [HALF_PROD_W-1:0] p_lo;
    logic [HALF_PROD_W-1:0] p_hi;
    logic [HALF_PROD_W-1:0] p_mid;
    logic [HALF_PROD_W-1:0] p_cross;
    logic [LIMB_PROD_W-1:0] prod;

    // Shift and XOR multiply, no carries between columns
    function automatic logic [HALF_PROD_W-1:0] clmul_half(
        input logic [LO_W-1:0] x,
        input logic [LO_W-1:0] y
    );
        logic [HALF_PROD_W-1:0] acc;
        acc = '0;
        for (int i = 0; i < LO_W; i++) begin
            if (y[i]) begin
                acc ^= HALF_PROD_W'(x) << i;
            end
        end
        return acc;
    endfunction

    assign a_lo  = limb_a[LO_W-1:0];
    assign a_hi  = LO_W'(limb_a[LIMB_W-1:LO_W]);
    assign b_lo  = limb_b[LO_W-1:0];
    assign b_hi  = LO_W'(limb_b[LIMB_W-1:LO_W]);
    assign a_mid = a_lo ^ a_hi;
    assign b_mid = b_lo ^ b_hi;

    assign p_lo  = clmul_half(a_lo, b_lo);
    assign p_hi  = clmul_half(a_hi, b_hi);
    assign p_mid = clmul_half(a_mid, b_mid);

    // Middle term of the Karatsuba split
    assign p_cross = p_mid ^ p_lo ^ p_hi;

    assign prod = (LIMB_PROD_W'(p_hi) << (2 * LO_W))
                ^ (LIMB_PROD_W'(p_cross) << LO_W)
                ^ LIMB_PROD_W'(p_lo);

    always_ff @(posedge clk) begin
        if (reset) begin
            pp_valid <= 1'b0;
        end else begin
            pp_valid <= issue_valid;
        end
    end

    // Tag travels with its product
    always_ff @(posedge clk) begin
        if (issue_valid) begin
            pp.prod   <= prod;
            pp.offset <= issue_tag.offset;
            pp.first  <= issue_tag.first;
            pp.last   <= issue_tag.last;
        end
    end

endmodule

//--- verilog/gf2_mul_pkg.sv
package gf2_mul_pkg;

    // ************************************************************************
    // Polynomial sizes
    // ************************************************************************

    localparam int LIMB_W      = 71;
    localparam int NUM_LIMBS   = 4;
    localparam int OPERAND_W   = LIMB_W * NUM_LIMBS;
    // Top bit of the product word is always zero
    localparam int PRODUCT_W   = 2 * OPERAND_W;
    localparam int LIMB_PROD_W = 2 * LIMB_W - 1;

    // Limb pair counter, high half picks the a limb and low half the b limb
    localparam int STEP_W      = 4;
    // Sum of two limb indices, 0 to 6
    localparam int OFFSET_W    = 3;

    // ************************************************************************
    // Channel types
    // ************************************************************************

    typedef union packed {
        logic [OPERAND_W-1:0]             flat;
        logic [NUM_LIMBS-1:0][LIMB_W-1:0] limb;
    } operand_u;

    typedef struct packed {
        operand_u a;
        operand_u b;
    } mul_req_t;

    // Limb product with its place in the wide sum
    typedef struct packed {
        logic [LIMB_PROD_W-1:0] prod;
        logic [OFFSET_W-1:0]    offset;
        logic                   first;
        logic                   last;
    } partial_t;

endpackage
